/* dcache.f */
hw/dcache_pkg.sv
hw/dcache_req_decode.sv
hw/dcache_array.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_dcache \
  -Mdir obj_dir -o sim_dcache -f dcache.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

/* tests/dcache_tests.dat */
# op addr wdata mask size expected, numbers in hex
# op is R or W, expected is ignored for writes
R 10000148 00000000 f 4 4a5a0148
W 10000148 11223344 3 4 00000000
W 10000148 aabbccdd 8 4 00000000
R 10000148 00000000 f 4 aa5a3344
R 1000014c 00000000 f 4 4a5a014c
W 10000170 01020304 f 4 00000000
R 20000148 00000000 f 4 7a5a0148
R 20000170 00000000 f 4 7a5a0170
R 10000148 00000000 f 4 aa5a3344
R 10000170 00000000 f 4 01020304
R 1000017c 00000000 f 4 4a5a017c
W 20000150 deadbeef 6 4 00000000
R 20000150 00000000 f 4 7aadbe50
R 10000150 00000000 f 4 4a5a0150
R 20000150 00000000 f 4 7aadbe50
R 00001fc4 00000000 f 4 5a5a1fc4
W a0000011 0000ab00 f 1 00000000
W a0000012 12340000 f 2 00000000
W a0000020 cafef00d f 4 00000000
R a0000011 00000000 f 1 000000ab
R a0000012 00000000 f 2 00001234
R a0000010 00000000 f 4 1234ab10
R a0000020 00000000 f 4 cafef00d
R a0000023 00000000 f 1 000000ca
R a0000030 00000000 f 2 00000030
R a0000032 00000000 f 2 0000fa5a

/* tests/tb_dcache.sv */
module tb_dcache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLES_PER_OP = 300;
  localparam int MAX_OPS       = 64;

  logic        clk;
  logic        rst;
  logic [31:0] mem_addr;
  logic        mem_valid;
  logic        mem_write;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_mask;
  logic [3:0]  mem_size;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic [31:0] ram_raddr;
  logic        ram_rvalid;
  logic [3:0]  ram_rsize;
  logic [7:0]  ram_rlen;
  logic        ram_rready;
  logic [31:0] ram_rdata;
  logic [31:0] ram_waddr;
  logic        ram_wvalid;
  logic [3:0]  ram_wmask;
  logic [3:0]  ram_wsize;
  logic [7:0]  ram_wlen;
  logic [31:0] ram_wdata;
  logic        ram_wready;

  // operations from the data file
  logic [7:0]  op_kind  [MAX_OPS];
  logic [31:0] op_addr  [MAX_OPS];
  logic [31:0] op_wdata [MAX_OPS];
  logic [3:0]  op_mask  [MAX_OPS];
  logic [3:0]  op_size  [MAX_OPS];
  logic [31:0] op_exp   [MAX_OPS];
  int          n_ops;

  // expected tag state per line
  logic        sh_valid [128];
  logic [18:0] sh_tag   [128];
  logic        sh_dirty [128];

  // burst bookkeeping for the current op
  logic        r_open;
  logic        w_open;
  int          r_cnt;
  int          w_cnt;
  int          r_beats;
  int          w_beats;
  logic [31:0] exp_raddr;
  logic [7:0]  exp_rlen;
  logic [3:0]  exp_rsize;
  logic [31:0] exp_waddr;
  logic [7:0]  exp_wlen;
  logic [3:0]  exp_wsize;
  logic [3:0]  exp_wmask;
  logic [31:0] exp_wdata;
  logic        exp_wdata_on;
  int          cycles;
  int          limit;

  dcache_top dcache_top_i (
    .clk         (clk),
    .rst         (rst),
    .mem_addr_i  (mem_addr),
    .mem_valid_i (mem_valid),
    .mem_write_i (mem_write),
    .mem_wdata_i (mem_wdata),
    .mem_mask_i  (mem_mask),
    .mem_size_i  (mem_size),
    .mem_rdata_o (mem_rdata),
    .mem_ready_o (mem_ready),
    .ram_raddr_o (ram_raddr),
    .ram_rvalid_o(ram_rvalid),
    .ram_rsize_o (ram_rsize),
    .ram_rlen_o  (ram_rlen),
    .ram_rready_i(ram_rready),
    .ram_rdata_i (ram_rdata),
    .ram_waddr_o (ram_waddr),
    .ram_wvalid_o(ram_wvalid),
    .ram_wmask_o (ram_wmask),
    .ram_wsize_o (ram_wsize),
    .ram_wlen_o  (ram_wlen),
    .ram_wdata_o (ram_wdata),
    .ram_wready_i(ram_wready)
  );

  tb_mem_model mem_model_i (
    .clk     (clk),
    .raddr_i (ram_raddr),
    .rvalid_i(ram_rvalid),
    .rlen_i  (ram_rlen),
    .rready_o(ram_rready),
    .rdata_o (ram_rdata),
    .waddr_i (ram_waddr),
    .wvalid_i(ram_wvalid),
    .wmask_i (ram_wmask),
    .wlen_i  (ram_wlen),
    .wdata_i (ram_wdata),
    .wready_o(ram_wready)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic wrong_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic fail_with(input string msg);
    $display("%s, at %0t ns", msg, $time);
    abort_run();
  endtask

  // byte, halfword or full word lanes
  function automatic logic [3:0] lanes_for(input logic [31:0] addr, input logic [3:0] size);
    logic [3:0] lanes;
    lanes = 4'b0000;
    if (size == 4'd1) begin
      lanes[addr[1:0]] = 1'b1;
    end else if (size == 4'd2) begin
      lanes = addr[1] ? 4'b1100 : 4'b0011;
    end else begin
      lanes = 4'b1111;
    end
    return lanes;
  endfunction

  task automatic load_ops();
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  m;
    logic [3:0]  s;
    logic [31:0] e;
    fd = $fopen("tests/dcache_tests.dat", "r");
    assert (fd != 0) else fail_with("cannot open tests/dcache_tests.dat");
    n_ops = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%c %h %h %h %h %h", kind, a, d, m, s, e);
      assert (fields == 6) else fail_with("malformed line in the data file");
      assert (kind == "R" || kind == "W") else fail_with("unknown operation in the data file");
      assert (n_ops < MAX_OPS) else fail_with("too many operations in the data file");
      op_kind[n_ops]  = kind;
      op_addr[n_ops]  = a;
      op_wdata[n_ops] = d;
      op_mask[n_ops]  = m;
      op_size[n_ops]  = s;
      op_exp[n_ops]   = e;
      n_ops++;
    end
    $fclose(fd);
  endtask

  // nothing may leave the dut during reset and the valid clearing walk
  task automatic expect_quiet();
    assert (mem_ready == 1'b0) else wrong_value("mem_ready_o", 32'(mem_ready), 32'h0);
    assert (ram_rvalid == 1'b0) else wrong_value("ram_rvalid_o", 32'(ram_rvalid), 32'h0);
    assert (ram_wvalid == 1'b0) else wrong_value("ram_wvalid_o", 32'(ram_wvalid), 32'h0);
  endtask

  // called at each falling edge while an op is open
  task automatic watch_ports();
    if (ram_rvalid) begin
      assert (ram_raddr == exp_raddr) else wrong_value("ram_raddr_o", ram_raddr, exp_raddr);
      assert (ram_rlen == exp_rlen) else wrong_value("ram_rlen_o", 32'(ram_rlen), 32'(exp_rlen));
      assert (ram_rsize == exp_rsize)
        else wrong_value("ram_rsize_o", 32'(ram_rsize), 32'(exp_rsize));
      r_open = 1'b1;
      if (ram_rready) begin
        r_cnt++;
        r_beats++;
        if (r_cnt == int'(ram_rlen) + 1) begin
          r_open = 1'b0;
          r_cnt  = 0;
        end
      end
    end else begin
      assert (!r_open) else fail_with("read valid fell before the last beat of its burst");
    end
    if (ram_wvalid) begin
      assert (ram_waddr == exp_waddr) else wrong_value("ram_waddr_o", ram_waddr, exp_waddr);
      assert (ram_wlen == exp_wlen) else wrong_value("ram_wlen_o", 32'(ram_wlen), 32'(exp_wlen));
      assert (ram_wsize == exp_wsize)
        else wrong_value("ram_wsize_o", 32'(ram_wsize), 32'(exp_wsize));
      assert (ram_wmask == exp_wmask)
        else wrong_value("ram_wmask_o", 32'(ram_wmask), 32'(exp_wmask));
      // io write data goes out unchanged
      if (exp_wdata_on) begin
        assert (ram_wdata == exp_wdata) else wrong_value("ram_wdata_o", ram_wdata, exp_wdata);
      end
      w_open = 1'b1;
      if (ram_wready) begin
        w_cnt++;
        w_beats++;
        if (w_cnt == int'(ram_wlen) + 1) begin
          w_open = 1'b0;
          w_cnt  = 0;
        end
      end
    end else begin
      assert (!w_open) else fail_with("write valid fell before the last beat of its burst");
    end
  endtask

  task automatic run_op(input int i);
    logic        is_wr;
    logic        unc;
    logic [6:0]  idx;
    logic [18:0] tag;
    logic        hit;
    int          exp_rbeats;
    int          exp_wbeats;
    is_wr = op_kind[i] == "W";
    unc   = op_addr[i][31:28] == 4'ha;
    idx   = op_addr[i][12:6];
    tag   = op_addr[i][31:13];
    hit   = sh_valid[idx] && sh_tag[idx] == tag;
    // expected memory traffic
    exp_wdata_on = unc && is_wr;
    exp_wdata    = op_wdata[i];
    if (unc) begin
      exp_raddr  = op_addr[i];
      exp_waddr  = op_addr[i];
      exp_rlen   = 8'd0;
      exp_wlen   = 8'd0;
      exp_rsize  = op_size[i];
      exp_wsize  = op_size[i];
      exp_wmask  = lanes_for(op_addr[i], op_size[i]);
      exp_rbeats = is_wr ? 0 : 1;
      exp_wbeats = is_wr ? 1 : 0;
    end else begin
      // miss refills the line, a dirty victim goes out first
      exp_raddr  = {tag, idx, 6'b0};
      exp_waddr  = {sh_tag[idx], idx, 6'b0};
      exp_rlen   = 8'd15;
      exp_wlen   = 8'd15;
      // bursts move whole words
      exp_rsize  = 4'd4;
      exp_wsize  = 4'd4;
      exp_wmask  = 4'b1111;
      exp_rbeats = hit ? 0 : 16;
      exp_wbeats = (!hit && sh_valid[idx] && sh_dirty[idx]) ? 16 : 0;
    end
    r_beats = 0;
    w_beats = 0;
    @(posedge clk);
    #1;
    mem_valid = 1'b1;
    mem_write = is_wr;
    mem_addr  = op_addr[i];
    mem_wdata = op_wdata[i];
    mem_mask  = op_mask[i];
    mem_size  = op_size[i];
    do begin
      @(negedge clk);
      cycles++;
      assert (cycles <= limit) else fail_with("timeout, mem_ready_o never came");
      watch_ports();
    end while (!mem_ready);
    assert (r_beats == exp_rbeats)
      else wrong_value("read beat count", 32'(r_beats), 32'(exp_rbeats));
    assert (w_beats == exp_wbeats)
      else wrong_value("write beat count", 32'(w_beats), 32'(exp_wbeats));
    if (!is_wr) begin
      assert (mem_rdata == op_exp[i]) else wrong_value("mem_rdata_o", mem_rdata, op_exp[i]);
    end
    if (!unc) begin
      // refill leaves the line clean, a write dirties it
      sh_dirty[idx] = (hit ? sh_dirty[idx] : 1'b0) | is_wr;
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = tag;
    end
  endtask

  initial begin
    rst       = 1'b1;
    mem_valid = 1'b0;
    mem_write = 1'b0;
    mem_addr  = 32'h0;
    mem_wdata = 32'h0;
    mem_mask  = 4'h0;
    mem_size  = 4'h0;
    r_open    = 1'b0;
    w_open    = 1'b0;
    r_cnt     = 0;
    w_cnt     = 0;
    cycles    = 0;
    for (int i = 0; i < 128; i++) begin
      sh_valid[i] = 1'b0;
      sh_tag[i]   = '0;
      sh_dirty[i] = 1'b0;
    end
    load_ops();
    limit = n_ops * CYCLES_PER_OP;
    // first request already waits through reset and the walk
    if (n_ops > 0) begin
      mem_valid = 1'b1;
      mem_write = op_kind[0] == "W";
      mem_addr  = op_addr[0];
      mem_wdata = op_wdata[0];
      mem_mask  = op_mask[0];
      mem_size  = op_size[0];
    end
    // 16 cycles of reset
    @(posedge clk);
    repeat (15) begin
      @(negedge clk);
      expect_quiet();
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
    // one cycle per line to clear valid bits
    repeat (128) begin
      @(negedge clk);
      expect_quiet();
    end
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    @(posedge clk);
    #1;
    mem_valid = 1'b0;
    repeat (4) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

/* tests/tb_mem_model.sv */
module tb_mem_model (
  input  logic        clk,
  input  logic [31:0] raddr_i,
  input  logic        rvalid_i,
  input  logic [7:0]  rlen_i,
  output logic        rready_o,
  output logic [31:0] rdata_o,
  input  logic [31:0] waddr_i,
  input  logic        wvalid_i,
  input  logic [3:0]  wmask_i,
  input  logic [7:0]  wlen_i,
  input  logic [31:0] wdata_i,
  output logic        wready_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'h66d1_f7b4;
  localparam logic [31:0] FILL = 32'h5a5a_0000;

  // sparse store, word aligned keys
  logic [31:0] words [logic [31:0]];
  logic [31:0] lcg;
  // beats already done in the open burst
  int          r_beat;
  int          w_beat;
  logic        r_fire;
  logic        w_fire;
  logic [7:0]  r_len_s;
  logic [7:0]  w_len_s;
  logic [31:0] w_addr_s;
  logic [31:0] w_data_s;
  logic [3:0]  w_mask_s;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // never written words read back as their address xor the fill
  function automatic logic [31:0] peek(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    if (words.exists(a)) begin
      return words[a];
    end
    return a ^ FILL;
  endfunction

  // masked bytes replace the old ones
  function automatic void poke(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] mask);
    logic [31:0] a;
    logic [31:0] merged;
    a = {addr[31:2], 2'b00};
    merged = peek(a);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        merged[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    words[a] = merged;
  endfunction

  initial begin
    lcg      = SEED;
    rready_o = 1'b0;
    wready_o = 1'b0;
    rdata_o  = 32'h0;
    r_beat   = 0;
    w_beat   = 0;
    forever begin
      // outputs of the dut are settled at the falling edge
      @(negedge clk);
      r_fire   = rvalid_i && rready_o;
      w_fire   = wvalid_i && wready_o;
      r_len_s  = rlen_i;
      w_len_s  = wlen_i;
      w_addr_s = waddr_i + 32'(w_beat * 4);
      w_data_s = wdata_i;
      w_mask_s = wmask_i;
      @(posedge clk);
      #1;
      if (w_fire) begin
        poke(w_addr_s, w_data_s, w_mask_s);
        w_beat = (w_beat == int'(w_len_s)) ? 0 : w_beat + 1;
      end
      if (r_fire) begin
        r_beat = (r_beat == int'(r_len_s)) ? 0 : r_beat + 1;
      end
      // about three cycles in four ready
      lcg      = lcg_next(lcg);
      rready_o = lcg[17:16] != 2'b00;
      wready_o = lcg[19:18] != 2'b00;
      // burst address stays at the line base
      rdata_o  = rvalid_i ? peek(raddr_i + 32'(r_beat * 4)) : 32'h0;
    end
  end

endmodule

/* hw/dcache_top.sv */
module dcache_top #(
  parameter int INDEX_W  = dcache_pkg::INDEX_W,
  parameter int OFFSET_W = dcache_pkg::OFFSET_W
) (
  input  logic                          clk,
  input  logic                          rst,
  // core side
  input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic                          mem_valid_i,
  input  logic                          mem_write_i,
  input  logic [dcache_pkg::WORD_W-1:0] mem_wdata_i,
  input  logic [3:0]                    mem_mask_i,
  input  logic [3:0]                    mem_size_i,
  output logic [dcache_pkg::WORD_W-1:0] mem_rdata_o,
  output logic                          mem_ready_o,
  // memory read port
  output logic [dcache_pkg::ADDR_W-1:0] ram_raddr_o,
  output logic                          ram_rvalid_o,
  output logic [3:0]                    ram_rsize_o,
  output logic [7:0]                    ram_rlen_o,
  input  logic                          ram_rready_i,
  input  logic [dcache_pkg::WORD_W-1:0] ram_rdata_i,
  // memory write port
  output logic [dcache_pkg::ADDR_W-1:0] ram_waddr_o,
  output logic                          ram_wvalid_o,
  output logic [3:0]                    ram_wmask_o,
  output logic [3:0]                    ram_wsize_o,
  output logic [7:0]                    ram_wlen_o,
  output logic [dcache_pkg::WORD_W-1:0] ram_wdata_o,
  input  logic                          ram_wready_i
);
  import dcache_pkg::*;

  tag_t              tag;
  index_t            index;
  logic [3:0]        word;
  logic              uncached;
  logic [WORD_W-1:0] wbits;
  logic [3:0]        lane_mask;
  logic              hit;
  logic              victim_dirty;
  tag_t              victim_tag;
  logic [WORD_W-1:0] rdata;
  logic [WORD_W-1:0] wb_data;
  logic [WORD_W-1:0] unc_rdata;
  logic              store_busy;
  beat_t             beat;
  logic              tag_we;
  logic              dirty;
  logic              data_we;
  logic              refill;

  dcache_req_decode #(
    .INDEX_W (INDEX_W),
    .OFFSET_W(OFFSET_W)
  ) req_decode_i (
    .mem_addr_i (mem_addr_i),
    .mem_mask_i (mem_mask_i),
    .mem_size_i (mem_size_i),
    .tag_o      (tag),
    .index_o    (index),
    .word_o     (word),
    .uncached_o (uncached),
    .wbits_o    (wbits),
    .lane_mask_o(lane_mask)
  );

  dcache_store #(
    .INDEX_W(INDEX_W)
  ) store_i (
    .clk           (clk),
    .rst           (rst),
    .index_i       (index),
    .word_i        (word),
    .tag_i         (tag),
    .beat_i        (beat),
    .tag_we_i      (tag_we),
    .dirty_i       (dirty),
    .data_we_i     (data_we),
    .refill_i      (refill),
    .wdata_i       (mem_wdata_i),
    .wbits_i       (wbits),
    .ram_rdata_i   (ram_rdata_i),
    .hit_o         (hit),
    .victim_dirty_o(victim_dirty),
    .victim_tag_o  (victim_tag),
    .rdata_o       (rdata),
    .wb_data_o     (wb_data),
    .busy_o        (store_busy)
  );

  dcache_ctrl #(
    .OFFSET_W(OFFSET_W)
  ) ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .mem_valid_i   (mem_valid_i),
    .mem_write_i   (mem_write_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wdata_i   (mem_wdata_i),
    .mem_size_i    (mem_size_i),
    .tag_i         (tag),
    .index_i       (index),
    .uncached_i    (uncached),
    .lane_mask_i   (lane_mask),
    .hit_i         (hit),
    .victim_dirty_i(victim_dirty),
    .victim_tag_i  (victim_tag),
    .wb_data_i     (wb_data),
    .store_busy_i  (store_busy),
    .ram_rdata_i   (ram_rdata_i),
    .ram_rready_i  (ram_rready_i),
    .ram_wready_i  (ram_wready_i),
    .ram_raddr_o   (ram_raddr_o),
    .ram_rvalid_o  (ram_rvalid_o),
    .ram_rsize_o   (ram_rsize_o),
    .ram_rlen_o    (ram_rlen_o),
    .ram_waddr_o   (ram_waddr_o),
    .ram_wvalid_o  (ram_wvalid_o),
    .ram_wmask_o   (ram_wmask_o),
    .ram_wsize_o   (ram_wsize_o),
    .ram_wlen_o    (ram_wlen_o),
    .ram_wdata_o   (ram_wdata_o),
    .beat_o        (beat),
    .tag_we_o      (tag_we),
    .dirty_o       (dirty),
    .data_we_o     (data_we),
    .refill_o      (refill),
    .mem_ready_o   (mem_ready_o),
    .unc_rdata_o   (unc_rdata)
  );

  // io reads come from the latched beat
  // cached reads come from the array
  assign mem_rdata_o = uncached ? unc_rdata : rdata;

endmodule

/* hw/dcache_ctrl.sv */
module dcache_ctrl #(
  parameter int OFFSET_W = dcache_pkg::OFFSET_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          mem_valid_i,
  input  logic                          mem_write_i,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [dcache_pkg::WORD_W-1:0] mem_wdata_i,
  input  logic [3:0]                    mem_size_i,
  input  dcache_pkg::tag_t              tag_i,
  input  dcache_pkg::index_t            index_i,
  input  logic                          uncached_i,
  input  logic [3:0]                    lane_mask_i,
  input  logic                          hit_i,
  input  logic                          victim_dirty_i,
  input  dcache_pkg::tag_t              victim_tag_i,
  input  logic [dcache_pkg::WORD_W-1:0] wb_data_i,
  input  logic                          store_busy_i,
  input  logic [dcache_pkg::WORD_W-1:0] ram_rdata_i,
  input  logic                          ram_rready_i,
  input  logic                          ram_wready_i,
  output logic [dcache_pkg::ADDR_W-1:0] ram_raddr_o,
  output logic                          ram_rvalid_o,
  output logic [3:0]                    ram_rsize_o,
  output logic [7:0]                    ram_rlen_o,
  output logic [dcache_pkg::ADDR_W-1:0] ram_waddr_o,
  output logic                          ram_wvalid_o,
  output logic [3:0]                    ram_wmask_o,
  output logic [3:0]                    ram_wsize_o,
  output logic [7:0]                    ram_wlen_o,
  output logic [dcache_pkg::WORD_W-1:0] ram_wdata_o,
  output dcache_pkg::beat_t             beat_o,
  output logic                          tag_we_o,
  output logic                          dirty_o,
  output logic                          data_we_o,
  output logic                          refill_o,
  output logic                          mem_ready_o,
  output logic [dcache_pkg::WORD_W-1:0] unc_rdata_o
);
  import dcache_pkg::*;

  ctrl_state_t       state;
  logic              accept;
  logic              write_hit;
  logic              r_done;
  logic              w_done;
  logic              last_beat;
  logic [ADDR_W-1:0] line_base;
  logic [ADDR_W-1:0] victim_base;
  logic [WORD_W-1:0] unc_wdata;
  logic [WORD_W-1:0] unc_shift;

  // one new request per ready pulse
  // nothing is taken in the ready cycle itself
  assign accept    = state == IDLE && mem_valid_i && !mem_ready_o && !store_busy_i;
  assign write_hit = accept && !uncached_i && mem_write_i && hit_i;

  assign r_done    = ram_rvalid_o && ram_rready_i;
  assign w_done    = ram_wvalid_o && ram_wready_i;
  assign last_beat = beat_o == BURST_LEN[3:0];

  assign line_base   = {tag_i, index_i, {OFFSET_W{1'b0}}};
  assign victim_base = {victim_tag_i, index_i, {OFFSET_W{1'b0}}};

  // store side
  // bursts address by beat and refill takes memory data
  assign refill_o  = state == REFILL || state == WRITE_BACK;
  assign data_we_o = write_hit || (state == REFILL && r_done);
  // tag goes valid with the last refill beat
  assign tag_we_o  = write_hit || (state == REFILL && r_done && last_beat);
  // dirty on a write hit and clean after refill
  assign dirty_o   = state == IDLE;

  // eviction streams straight from the array
  assign ram_wdata_o = state == WRITE_BACK ? wb_data_i : unc_wdata;

  // requested lane down to bit 0
  assign unc_shift = ram_rdata_i >> {mem_addr_i[1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      mem_ready_o  <= 1'b0;
      ram_rvalid_o <= 1'b0;
      ram_wvalid_o <= 1'b0;
      beat_o       <= '0;
    end else begin
      mem_ready_o <= 1'b0;
      case (state)
        IDLE: begin
          beat_o <= '0;
          if (accept) begin
            if (uncached_i && mem_write_i) begin
              state        <= UNC_WRITE;
              ram_wvalid_o <= 1'b1;
            end else if (uncached_i) begin
              state        <= UNC_READ;
              ram_rvalid_o <= 1'b1;
            end else if (hit_i) begin
              // read or write hit done in one cycle
              mem_ready_o <= 1'b1;
            end else if (victim_dirty_i) begin
              state        <= WRITE_BACK;
              ram_wvalid_o <= 1'b1;
            end else begin
              state        <= REFILL;
              ram_rvalid_o <= 1'b1;
            end
          end
        end
        WRITE_BACK: begin
          if (w_done) begin
            // wraps to 0 for the refill
            beat_o <= beat_o + 1'b1;
            if (last_beat) begin
              state        <= REFILL;
              ram_wvalid_o <= 1'b0;
              ram_rvalid_o <= 1'b1;
            end
          end
        end
        REFILL: begin
          if (r_done) begin
            beat_o <= beat_o + 1'b1;
            // request is looked up again as a hit
            if (last_beat) begin
              state        <= IDLE;
              ram_rvalid_o <= 1'b0;
            end
          end
        end
        UNC_READ: begin
          if (r_done) begin
            state        <= IDLE;
            ram_rvalid_o <= 1'b0;
            mem_ready_o  <= 1'b1;
          end
        end
        UNC_WRITE: begin
          if (w_done) begin
            state        <= IDLE;
            ram_wvalid_o <= 1'b0;
            mem_ready_o  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request fields latched on accept
  // held while valid is up
  always_ff @(posedge clk) begin
    if (accept) begin
      ram_raddr_o <= uncached_i ? mem_addr_i : line_base;
      ram_rsize_o <= uncached_i ? mem_size_i : SIZE_WORD;
      ram_rlen_o  <= uncached_i ? 8'd0 : BURST_LEN;
      ram_waddr_o <= uncached_i ? mem_addr_i : victim_base;
      ram_wmask_o <= uncached_i ? lane_mask_i : 4'b1111;
      ram_wsize_o <= uncached_i ? mem_size_i : SIZE_WORD;
      ram_wlen_o  <= uncached_i ? 8'd0 : BURST_LEN;
      unc_wdata   <= mem_wdata_i;
    end
    // zero extended io read data
    if (state == UNC_READ && r_done) begin
      case (mem_size_i)
        SIZE_BYTE: unc_rdata_o <= {24'b0, unc_shift[7:0]};
        SIZE_HALF: unc_rdata_o <= {16'b0, unc_shift[15:0]};
        default:   unc_rdata_o <= ram_rdata_i;
      endcase
    end
  end

  // one direction on the memory port at a time
  assert property (@(posedge clk) disable iff (rst) !(ram_rvalid_o && ram_wvalid_o));

  // beat count never runs past the active length code
  assert property (@(posedge clk) disable iff (rst)
    ram_rvalid_o |-> 8'(beat_o) <= ram_rlen_o);
  assert property (@(posedge clk) disable iff (rst)
    ram_wvalid_o |-> 8'(beat_o) <= ram_wlen_o);

endmodule

/* hw/dcache_store.sv */
module dcache_store #(
  parameter int INDEX_W = dcache_pkg::INDEX_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  dcache_pkg::index_t            index_i,
  input  logic [3:0]                    word_i,
  input  dcache_pkg::tag_t              tag_i,
  input  dcache_pkg::beat_t             beat_i,
  input  logic                          tag_we_i,
  input  logic                          dirty_i,
  input  logic                          data_we_i,
  input  logic                          refill_i,
  input  logic [dcache_pkg::WORD_W-1:0] wdata_i,
  input  logic [dcache_pkg::WORD_W-1:0] wbits_i,
  input  logic [dcache_pkg::WORD_W-1:0] ram_rdata_i,
  output logic                          hit_o,
  output logic                          victim_dirty_o,
  output dcache_pkg::tag_t              victim_tag_o,
  output logic [dcache_pkg::WORD_W-1:0] rdata_o,
  output logic [dcache_pkg::WORD_W-1:0] wb_data_o,
  output logic                          busy_o
);
  import dcache_pkg::*;

  localparam int LINES = 1 << INDEX_W;
  localparam int WORDS = LINES * WORDS_PER_LINE;

  index_t            rst_idx;
  logic              tag_we;
  index_t            tag_waddr;
  tag_entry_t        tag_wr;
  tag_entry_t        tag_rd;
  logic [3:0]        word_sel;
  logic [WORD_W-1:0] data_wr;
  logic [WORD_W-1:0] data_rd;

  // walk every line once after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o  <= 1'b1;
      rst_idx <= '0;
    end else if (busy_o) begin
      rst_idx <= rst_idx + 1'b1;
      if (rst_idx == index_t'(LINES - 1)) begin
        busy_o <= 1'b0;
      end
    end
  end

  // walk owns the tag write port until done
  assign tag_we    = busy_o | tag_we_i;
  assign tag_waddr = busy_o ? rst_idx : index_i;

  always_comb begin
    tag_wr = '0;
    if (!busy_o) begin
      tag_wr.valid = 1'b1;
      tag_wr.dirty = dirty_i;
      tag_wr.tag   = tag_i;
    end
  end

  dcache_array #(
    .entry_t(tag_entry_t),
    .DEPTH  (LINES)
  ) tag_array_i (
    .clk    (clk),
    .we_i   (tag_we),
    .waddr_i(tag_waddr),
    .wdata_i(tag_wr),
    .raddr_i(index_i),
    .rdata_o(tag_rd)
  );

  assign hit_o          = tag_rd.valid && (tag_rd.tag == tag_i);
  assign victim_dirty_o = tag_rd.valid && tag_rd.dirty;
  assign victim_tag_o   = tag_rd.tag;

  // bursts step through the line by beat
  assign word_sel = refill_i ? beat_i : word_i;

  // refill takes the memory beat
  // a write hit keeps the unmasked bytes
  assign data_wr = refill_i ? ram_rdata_i : (data_rd & ~wbits_i) | (wdata_i & wbits_i);

  dcache_array #(
    .entry_t(logic [WORD_W-1:0]),
    .DEPTH  (WORDS)
  ) data_array_i (
    .clk    (clk),
    .we_i   (data_we_i),
    .waddr_i({index_i, word_sel}),
    .wdata_i(data_wr),
    .raddr_i({index_i, word_sel}),
    .rdata_o(data_rd)
  );

  assign rdata_o   = data_rd;
  assign wb_data_o = data_rd;

endmodule

/* hw/dcache_array.sv */
module dcache_array #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 128
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  entry_t                   wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output entry_t                   rdata_o
);

  entry_t mem [DEPTH];

  // write on the edge
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read is combinational so hits answer in the same cycle
  assign rdata_o = mem[raddr_i];

  // an unknown write address would corrupt an arbitrary entry
  assert property (@(posedge clk) we_i |-> !$isunknown(waddr_i));

endmodule

/* hw/dcache_req_decode.sv */
module dcache_req_decode #(
  parameter int INDEX_W  = dcache_pkg::INDEX_W,
  parameter int OFFSET_W = dcache_pkg::OFFSET_W
) (
  input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [3:0]                    mem_mask_i,
  input  logic [3:0]                    mem_size_i,
  output dcache_pkg::tag_t              tag_o,
  output dcache_pkg::index_t            index_o,
  output logic [3:0]                    word_o,
  output logic                          uncached_o,
  output logic [31:0]                   wbits_o,
  output logic [3:0]                    lane_mask_o
);
  import dcache_pkg::*;

  // tag / index / word split
  // byte bits within the word are not needed here
  assign tag_o   = mem_addr_i[ADDR_W-1:INDEX_W+OFFSET_W];
  assign index_o = mem_addr_i[INDEX_W+OFFSET_W-1:OFFSET_W];
  assign word_o  = mem_addr_i[OFFSET_W-1:2];

  // io space bypasses the arrays
  assign uncached_o = mem_addr_i[ADDR_W-1 -: 4] == UNCACHED_TOP;

  // byte enables to bit mask for the merge
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wbits_o[i*8 +: 8] = {8{mem_mask_i[i]}};
    end
  end

  // lanes for single beat io writes
  always_comb begin
    case (mem_size_i)
      SIZE_BYTE: lane_mask_o = 4'b0001 << mem_addr_i[1:0];
      SIZE_HALF: lane_mask_o = mem_addr_i[1] ? 4'b1100 : 4'b0011;
      // word and anything unknown
      default:   lane_mask_o = 4'b1111;
    endcase
  end

endmodule

/* hw/dcache_pkg.sv */
package dcache_pkg;

  // core address and data widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // 64 byte lines and 128 of them
  localparam int OFFSET_W       = 6;
  localparam int INDEX_W        = 7;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORDS_PER_LINE = 16;

  // length code of a full line burst
  localparam logic [7:0] BURST_LEN = 8'd15;

  // access size codes in bytes
  localparam logic [3:0] SIZE_BYTE = 4'd1;
  localparam logic [3:0] SIZE_HALF = 4'd2;
  localparam logic [3:0] SIZE_WORD = 4'd4;

  // top nibble of the uncached region
  localparam logic [3:0] UNCACHED_TOP = 4'ha;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [3:0]         beat_t;

  // one entry per line
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE_BACK,
    REFILL,
    UNC_READ,
    UNC_WRITE
  } ctrl_state_t;

endpackage
